/* src/div_defs.svh */
`ifndef DIV_DEFS_SVH
`define DIV_DEFS_SVH

// operand and result width
`define DIV_W 32

// wide enough for any shift or bit position count
`define DIV_SHW 6

// operand queue entries
`define OP_DEPTH 4

// result queue entries
`define RSP_DEPTH 4

`endif

/* src/div_pkg.sv */
`include "div_defs.svh"

package div_pkg;

	// one operand pair as pushed by the host
	typedef struct packed {
		logic signed [`DIV_W-1:0] dividend;
		logic signed [`DIV_W-1:0] divisor;
	} div_req_t;

	// one finished division
	typedef struct packed {
		logic signed [`DIV_W-1:0] quotient;  // truncated toward zero
		logic signed [`DIV_W-1:0] remainder; // sign follows the dividend
	} div_rsp_t;

endpackage

/* src/div_job_if.sv */
interface div_job_if
	import div_pkg::*;
();

	logic     start; // single cycle, only while busy is low
	div_req_t req;   // sampled by the core with start
	logic     busy;  // core owns a job
	logic     done;  // single cycle, once per start
	div_rsp_t rsp;   // valid with done

	// controller side
	modport ctrl (
		output start,
		output req,
		input  busy,
		input  done,
		input  rsp
	);

	// division core side
	modport core (
		input  start,
		input  req,
		output busy,
		output done,
		output rsp
	);

	// observers only
	modport mon (
		input start,
		input req,
		input busy,
		input done,
		input rsp
	);

endinterface

/* src/sync_fifo.sv */
module sync_fifo #(
	parameter type T     = logic [7:0],
	parameter int  DEPTH = 4
) (
	input  logic i_clk,
	input  logic i_rst,
	input  logic i_push,
	input  T     i_data,
	output logic o_full,
	input  logic i_pop,
	output T     o_data,
	output logic o_empty
);

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1; // pointer width
	localparam int CW = $clog2(DEPTH + 1);               // occupancy width

	T              mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [CW-1:0] count;
	logic          do_push;
	logic          do_pop;

	// pointer advance with wrap, depth need not be a power of two
	function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] ptr);
		return (ptr == AW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign o_full  = (count == CW'(DEPTH));
	assign o_empty = (count == '0);
	assign do_push = i_push && !o_full; // drop when full
	assign do_pop  = i_pop && !o_empty; // ignore when empty

	assign o_data = mem[rd_ptr]; // head shown without a read cycle

	always_ff @(posedge i_clk) begin
		if (do_push)
			mem[wr_ptr] <= i_data;
	end

	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= ptr_inc(wr_ptr);
			if (do_pop)
				rd_ptr <= ptr_inc(rd_ptr);
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // both or neither
			endcase
		end
	end

endmodule

/* src/norm_shift.sv */
`include "div_defs.svh"

module norm_shift (
	input  logic [`DIV_W-1:0]   i_data,
	output logic [`DIV_W-1:0]   o_data,
	output logic [`DIV_SHW-1:0] o_shift
);

	logic [`DIV_SHW-1:0] cnt;  // redundant sign bits below the msb
	logic                run;  // still inside the leading sign run
	logic                sgn;

	assign sgn = i_data[`DIV_W-1];

	// walk down from the bit under the sign
	// zero and all ones run to the end, count is then DIV_W-1
	always_comb begin
		cnt = '0;
		run = 1'b1;
		for (int i = `DIV_W - 2; i >= 0; i--) begin
			if (run && (i_data[i] == sgn))
				cnt = cnt + 1'b1;
			else
				run = 1'b0;
		end
	end

	// after the shift bits msb and msb-1 differ
	// unless the word had no significant bit at all
	assign o_data  = i_data << cnt;
	assign o_shift = cnt;

endmodule

/* src/nonrestoring_div.sv */
`include "div_defs.svh"

module nonrestoring_div
	import div_pkg::*;
(
	input  logic    i_clk,
	input  logic    i_rst,
	div_job_if.core job
);

	localparam int PW = `DIV_W + 3; // partial remainder, headroom for 2x divisor
	localparam int QW = `DIV_W + 1; // digit positions 0..DIV_W

	typedef enum logic [2:0] {
		S_IDLE,
		S_NORM, // normalize divisor
		S_LOAD, // load dividend, catch special operands
		S_ITER,
		S_CORQ, // correct quotient
		S_CORR, // correct remainder
		S_FIN
	} state_t;

	state_t                   state;
	logic signed [`DIV_W-1:0] dvd;
	logic signed [`DIV_W-1:0] dvs;
	logic signed [PW-1:0]     dvs_x;  // divisor sign extended
	logic signed [PW-1:0]     dn2;    // normalized divisor, doubled
	logic [`DIV_SHW-1:0]      sd;     // divisor normalizing shift
	logic signed [PW-1:0]     p;      // partial remainder at position k
	logic [`DIV_SHW-1:0]      k;      // current quotient bit position
	logic [QW-1:0]            qp;     // plus digits
	logic [QW-1:0]            qn;     // minus digits
	logic signed [PW-1:0]     rem;
	logic signed [`DIV_W-1:0] quo;
	logic                     fix_q;

	logic [`DIV_W-1:0]        ns_in;
	logic [`DIV_W-1:0]        ns_out;
	logic [`DIV_SHW-1:0]      ns_cnt;
	logic signed [PW-1:0]     ns_dbl;

	logic signed [PW-1:0]     add_a;
	logic signed [PW-1:0]     add_b;
	logic signed [PW-1:0]     add_sum;
	logic                     add_sub;

	logic                     zreg;
	logic                     it_end;
	logic signed [PW-1:0]     fin_val;
	logic [`DIV_SHW-1:0]      fin_sh;
	logic                     fix;
	logic [QW:0]              q_adj;
	logic                     div_zero;
	logic                     div_ovf;

	// one shifter, divisor in S_NORM, partial remainder otherwise
	assign ns_in = (state == S_NORM) ? dvs : p[`DIV_W-1:0];

	norm_shift u_norm (
		.i_data  (ns_in),
		.o_data  (ns_out),
		.o_shift (ns_cnt)
	);

	assign ns_dbl = {{2{ns_out[`DIV_W-1]}}, ns_out, 1'b0}; // one more doubling
	assign dvs_x  = dvs;

	// single add/subtract, subtract when signs agree
	assign add_a   = (state == S_ITER) ? p : rem;
	assign add_b   = (state == S_ITER) ? dn2 : dvs_x;
	assign add_sub = (add_a[PW-1] == add_b[PW-1]);
	assign add_sum = add_a + (add_sub ? ~add_b : add_b) + add_sub;

	// |p| below half the divisor scale gives a zero digit
	assign zreg = (p[PW-1:`DIV_W-1] == '0) || (p[PW-1:`DIV_W-1] == '1);

	// zero run reaching bit 0, or last nonzero digit
	assign it_end = zreg ? (ns_cnt >= k) : (k == '0);

	// scale back to the dividend grid
	assign fin_val = zreg ? p : add_sum;
	assign fin_sh  = sd + 1'b1 - k;

	// remainder on the wrong side of zero, or exactly +-divisor
	assign fix   = ((rem != '0) && (rem[PW-1] != dvd[`DIV_W-1])) || (add_sum == '0);
	assign q_adj = {1'b0, qp} - {1'b0, qn} + {{QW{fix & ~add_sub}}, fix};

	assign div_zero = (dvs == '0);
	assign div_ovf  = (dvd == {1'b1, {(`DIV_W-1){1'b0}}}) && (dvs == '1);

	assign job.busy = (state != S_IDLE);
	assign job.done = (state == S_FIN);
	assign job.rsp  = div_rsp_t'{quotient: quo, remainder: rem[`DIV_W-1:0]};

	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			state <= S_IDLE;
			k     <= '0;
			fix_q <= 1'b0;
		end else begin
			case (state)
				S_IDLE: if (job.start) state <= S_NORM;
				S_NORM: state <= S_LOAD;
				S_LOAD: begin
					k     <= sd + 1'b1; // top digit sits one above the divisor msb
					state <= (div_zero || div_ovf) ? S_FIN : S_ITER;
				end
				S_ITER: begin
					if (it_end)
						state <= S_CORQ;
					else if (zreg)
						k <= k - ns_cnt - 1'b1; // jump the whole zero run
					else
						k <= k - 1'b1;
				end
				S_CORQ: begin
					fix_q <= fix;
					state <= S_CORR;
				end
				S_CORR:  state <= S_FIN;
				S_FIN:   state <= S_IDLE;
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clk) begin
		case (state)
			S_IDLE: if (job.start) begin
				dvd <= job.req.dividend;
				dvs <= job.req.divisor;
			end
			S_NORM: begin
				sd  <= ns_cnt;
				dn2 <= ns_dbl;
			end
			S_LOAD: begin
				p  <= dvd;
				qp <= '0;
				qn <= '0;
				if (div_zero) begin
					quo <= dvd[`DIV_W-1] ? `DIV_W'(1) : '1;
					rem <= dvd;
				end else if (div_ovf) begin
					quo <= dvd;  // wraps to itself
					rem <= '0;
				end
			end
			S_ITER: begin
				if (!zreg) begin
					if (add_sub)
						qp[k] <= 1'b1;
					else
						qn[k] <= 1'b1;
				end
				if (it_end)
					rem <= fin_val >>> fin_sh;
				else if (zreg)
					p <= ns_dbl;
				else
					p <= add_sum <<< 1;
			end
			S_CORQ: quo <= q_adj[`DIV_W-1:0];
			S_CORR: if (fix_q) rem <= add_sum; // add back or subtract again
			default: ;
		endcase
	end

endmodule

/* src/div_ctrl.sv */
module div_ctrl
	import div_pkg::*;
(
	input  logic     i_clk,
	input  logic     i_rst,
	input  logic     i_op_empty,
	input  div_req_t i_op_head,
	output logic     o_op_pop,
	input  logic     i_rsp_full,
	output logic     o_rsp_push,
	output div_rsp_t o_rsp_data,
	div_job_if.ctrl  job
);

	logic issue;      // a job can be handed over
	logic start_pend; // issue registered, one per job

	// result slot reserved here stays free until done,
	// the core holds one job and nothing else pushes results
	assign issue = !i_op_empty && !i_rsp_full && !job.busy && !start_pend;

	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst)
			start_pend <= 1'b0;
		else
			start_pend <= issue;
	end

	// start and pop share the cycle, head still holds the job
	assign job.start = start_pend;
	assign job.req   = i_op_head;
	assign o_op_pop  = start_pend;

	// core result straight into the result queue
	assign o_rsp_push = job.done;
	assign o_rsp_data = job.rsp;

endmodule

/* src/div_unit_top.sv */
`include "div_defs.svh"

module div_unit_top
	import div_pkg::*;
(
	input  logic                     i_clk,
	input  logic                     i_rst,
	input  logic                     i_push,
	input  logic signed [`DIV_W-1:0] i_dividend,
	input  logic signed [`DIV_W-1:0] i_divisor,
	output logic                     o_op_full,
	input  logic                     i_pop,
	output logic                     o_rsp_valid,
	output logic signed [`DIV_W-1:0] o_quotient,
	output logic signed [`DIV_W-1:0] o_remainder
);

	div_req_t push_req;
	div_req_t op_head;
	logic     op_empty;
	logic     op_pop;
	div_rsp_t rsp_data;
	div_rsp_t rsp_head;
	logic     rsp_push;
	logic     rsp_full;
	logic     rsp_empty;

	div_job_if u_job ();

	assign push_req = '{dividend: i_dividend, divisor: i_divisor};

	sync_fifo #(.T(div_req_t), .DEPTH(`OP_DEPTH)) u_op_fifo (
		.i_clk   (i_clk),
		.i_rst   (i_rst),
		.i_push  (i_push),
		.i_data  (push_req),
		.o_full  (o_op_full),
		.i_pop   (op_pop),
		.o_data  (op_head),
		.o_empty (op_empty)
	);

	div_ctrl u_ctrl (
		.i_clk      (i_clk),
		.i_rst      (i_rst),
		.i_op_empty (op_empty),
		.i_op_head  (op_head),
		.o_op_pop   (op_pop),
		.i_rsp_full (rsp_full),
		.o_rsp_push (rsp_push),
		.o_rsp_data (rsp_data),
		.job        (u_job.ctrl)
	);

	nonrestoring_div u_core (
		.i_clk (i_clk),
		.i_rst (i_rst),
		.job   (u_job.core)
	);

	sync_fifo #(.T(div_rsp_t), .DEPTH(`RSP_DEPTH)) u_rsp_fifo (
		.i_clk   (i_clk),
		.i_rst   (i_rst),
		.i_push  (rsp_push),
		.i_data  (rsp_data),
		.o_full  (rsp_full),
		.i_pop   (i_pop),
		.o_data  (rsp_head),
		.o_empty (rsp_empty)
	);

	assign o_rsp_valid = !rsp_empty; // held until popped
	assign o_quotient  = rsp_head.quotient;
	assign o_remainder = rsp_head.remainder;

endmodule

/* verification/div_assertions.sv */
`include "div_defs.svh"

module div_assertions
	import div_pkg::*;
(
	input logic i_clk,
	input logic i_rst,
	input logic i_start,
	input logic i_busy,
	input logic i_done,
	input logic i_rsp_valid,
	input logic i_pop
);

	timeunit 1ns;
	timeprecision 100ps;

	logic job_open; // a start not yet answered by done

	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst)
			job_open <= 1'b0;
		else if (i_start)
			job_open <= 1'b1;
		else if (i_done)
			job_open <= 1'b0;
	end

	// hand over only to an idle core
	a_start_idle: assert property (@(posedge i_clk) disable iff (!i_rst)
		i_start |-> !i_busy) else $error("start raised while core busy");

	a_done_pulse: assert property (@(posedge i_clk) disable iff (!i_rst)
		i_done |=> !i_done) else $error("done held longer than one cycle");

	// head leaves only when the host pops it
	a_valid_fall: assert property (@(posedge i_clk) disable iff (!i_rst)
		$fell(i_rsp_valid) |-> $past(i_pop)) else $error("result lost without a pop");

	// strict start, done, start alternation
	a_start_done: assert property (@(posedge i_clk) disable iff (!i_rst)
		i_start |-> !job_open) else $error("second start before done");

	a_done_start: assert property (@(posedge i_clk) disable iff (!i_rst)
		i_done |-> job_open) else $error("done without a start");

endmodule

bind div_unit_top div_assertions u_assert (
	.i_clk       (i_clk),
	.i_rst       (i_rst),
	.i_start     (u_job.start),
	.i_busy      (u_job.busy),
	.i_done      (u_job.done),
	.i_rsp_valid (o_rsp_valid),
	.i_pop       (i_pop)
);

/* verification/tb_div_unit.sv */
`include "div_defs.svh"

module tb_div_unit
	import div_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int N_DIR     = 8;
	localparam int N_SPEC    = 4;
	localparam int N_RAND    = 200;
	localparam int N_BP      = `OP_DEPTH + `RSP_DEPTH + 1; // pushes before full must show
	localparam int OP_BUDGET = 2 * `DIV_W + 16;            // cycles allowed per operation
	localparam logic signed [`DIV_W-1:0] MOST_NEG = {1'b1, {(`DIV_W-1){1'b0}}};

	logic                     clk;
	logic                     rst;
	logic                     push;
	logic signed [`DIV_W-1:0] dividend;
	logic signed [`DIV_W-1:0] divisor;
	logic                     op_full;
	logic                     pop;
	logic                     rsp_valid;
	logic signed [`DIV_W-1:0] quotient;
	logic signed [`DIV_W-1:0] remainder;

	div_rsp_t    exp_q[$];      // expected results in push order
	logic [31:0] lfsr_state = 32'h3c121ba3;
	logic        pop_en;        // lets the compare process drain results
	int          errors;
	int          checks;
	int          tests_run;
	int          tests_failed;
	int          test_err0;
	int          results_seen;

	div_unit_top u_dut (
		.i_clk       (clk),
		.i_rst       (rst),
		.i_push      (push),
		.i_dividend  (dividend),
		.i_divisor   (divisor),
		.o_op_full   (op_full),
		.i_pop       (pop),
		.o_rsp_valid (rsp_valid),
		.o_quotient  (quotient),
		.o_remainder (remainder)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk; // 4 ns period
	end

	// taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state); // one step per bit
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	// magnitude cut to a random width so sign runs vary
	function automatic logic signed [`DIV_W-1:0] rand_operand();
		logic [31:0] w;
		logic [32:0] mask;
		logic [31:0] mag;
		logic [31:0] neg;
		w    = take_bits(5) + 1;
		mask = (33'd1 << w) - 33'd1;
		mag  = take_bits(32) & mask[31:0];
		neg  = take_bits(1);
		return neg[0] ? -mag : mag;
	endfunction

	function automatic div_rsp_t ref_div(input logic signed [`DIV_W-1:0] a,
		input logic signed [`DIV_W-1:0] b);
		div_rsp_t r;
		if (b == 0) begin
			if (a < 0)
				r.quotient = 1;
			else
				r.quotient = '1;
			r.remainder = a;
		end else if (a == MOST_NEG && b == -1) begin
			r.quotient  = a; // wraps onto itself
			r.remainder = '0;
		end else begin
			r.quotient  = a / b; // native truncation toward zero
			r.remainder = a % b;
		end
		return r;
	endfunction

	task automatic check_rsp(input string name, input div_rsp_t got, input div_rsp_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR t=%0t %s got %0d,%0d expected %0d,%0d", $time, name,
				got.quotient, got.remainder, exp.quotient, exp.remainder);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR t=%0t %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	// full sampled mid cycle is what the fifo sees at the next edge
	task automatic push_op(input logic signed [`DIV_W-1:0] a,
		input logic signed [`DIV_W-1:0] b, output bit acc);
		@(posedge clk);
		push     <= 1'b1;
		dividend <= a;
		divisor  <= b;
		@(negedge clk);
		acc = !op_full;
		if (acc)
			exp_q.push_back(ref_div(a, b));
	endtask

	task automatic stop_push();
		@(posedge clk);
		push <= 1'b0;
	endtask

	task automatic wait_drain();
		while (exp_q.size() != 0)
			@(posedge clk); // watchdog bounds this
	endtask

	task automatic run_single(input logic signed [`DIV_W-1:0] a,
		input logic signed [`DIV_W-1:0] b);
		bit acc;
		push_op(a, b, acc);
		stop_push();
		if (!acc) begin
			errors++;
			$display("push of %0d / %0d refused with an idle operand queue", a, b);
		end
		wait_drain();
	endtask

	task automatic open_test();
		test_err0 = errors;
	endtask

	task automatic close_test(input string name);
		tests_run++;
		if (errors != test_err0)
			tests_failed++;
		$display("test %0d %-14s %s", tests_run, name, (errors == test_err0) ? "ok" : "failed");
	endtask

	// compare and pop, two cycles per result
	initial begin
		div_rsp_t got;
		pop = 1'b0;
		forever begin
			@(negedge clk);
			if (pop_en && rsp_valid) begin
				got.quotient  = quotient;
				got.remainder = remainder;
				if (exp_q.size() == 0) begin
					errors++;
					$display("result at %0t arrived with no job outstanding", $time);
				end else
					check_rsp("{o_quotient,o_remainder}", got, exp_q.pop_front());
				results_seen++;
				@(posedge clk) pop <= 1'b1;
				@(posedge clk) pop <= 1'b0; // fifo drops the head here
			end
		end
	end

	initial begin
		repeat ((N_DIR + N_SPEC + N_RAND + N_BP) * OP_BUDGET) @(posedge clk);
		$display("watchdog expired, run timed out at %0t", $time);
		$display("=== FAIL ===");
		$finish;
	end

	initial begin
		bit                       acc;
		bit                       refused;
		int                       accepted;
		int                       seen0;
		logic signed [`DIV_W-1:0] a;
		logic signed [`DIV_W-1:0] b;
		rst      = 1'b0;
		push     = 1'b0;
		dividend = '0;
		divisor  = '0;
		pop_en   = 1'b0;
		repeat (3) @(posedge clk);
		rst <= 1'b1;
		@(negedge clk);

		open_test();
		check_flag("o_rsp_valid", rsp_valid, 1'b0);
		check_flag("o_op_full", op_full, 1'b0);
		close_test("reset");

		open_test();
		pop_en = 1'b1;
		run_single(100, 7);     // all four sign pairs
		run_single(-100, 7);
		run_single(100, -7);
		run_single(-100, -7);
		run_single(3, 10);      // dividend below divisor
		run_single(-5, -9);
		run_single(84, 12);     // exact
		run_single(12345, 1);
		close_test("directed");

		open_test();
		run_single(77, 0);
		run_single(-77, 0);
		run_single(0, 0);
		run_single(MOST_NEG, -1);
		close_test("special");

		open_test();
		for (int n = 0; n < N_RAND; n++) begin
			a   = rand_operand();
			b   = rand_operand();
			acc = 1'b0;
			while (!acc)
				push_op(a, b, acc); // retry while full
		end
		stop_push();
		wait_drain();
		close_test("random");

		open_test();
		pop_en   = 1'b0;
		accepted = 0;
		refused  = 1'b0;
		while (!refused && accepted < N_BP) begin
			a = rand_operand();
			b = rand_operand();
			push_op(a, b, acc);
			if (acc)
				accepted++;
			else
				refused = 1'b1;
		end
		stop_push();
		if (!refused) begin
			errors++;
			$display("o_op_full never rose after %0d accepted pushes", accepted);
		end
		seen0  = results_seen;
		pop_en = 1'b1;
		wait_drain();
		repeat (OP_BUDGET) @(posedge clk); // nothing further may appear
		@(negedge clk);
		check_flag("o_rsp_valid", rsp_valid, 1'b0);
		if (results_seen - seen0 != accepted) begin
			errors++;
			$display("drained %0d results for %0d accepted pushes", results_seen - seen0,
				accepted);
		end
		close_test("backpressure");

		$display("tests %0d failed %0d checks %0d errors %0d", tests_run, tests_failed,
			checks, errors);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

/* filelist.f */
+incdir+src
src/div_pkg.sv
src/div_job_if.sv
src/sync_fifo.sv
src/norm_shift.sv
src/nonrestoring_div.sv
src/div_ctrl.sv
src/div_unit_top.sv
verification/div_assertions.sv
verification/tb_div_unit.sv
